// File: src.f
+incdir+.
move_sort_pkg.sv
move_ram.sv
move_compare.sv
sort_scan_counter.sv
move_sort_ctrl.sv
move_sort.sv
move_sort_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the move sort testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f src.f --top-module move_sort_tb -o move_sort_sim

# A $fatal in the testbench gives a failing exit status
./obj_dir/move_sort_sim

// File: move_sort_tb.sv
`timescale 1ns/1ps

`include "move_sort_config.svh"

module move_sort_tb;

   localparam int CLK_PERIOD  = 10;
   localparam int MAX_ENTRIES = `MOVE_SORT_MAX_POSITIONS;
   localparam int N_ENTRIES   = 48;
   // Worst case per pair is one trip READ_WS_0 through INNER
   localparam int PAIR_CYCLES = int'(move_sort_pkg::INNER) - int'(move_sort_pkg::READ_WS_0) + 1;
   localparam int SORT_CYCLES = (MAX_ENTRIES - 1) * ((MAX_ENTRIES - 1) * PAIR_CYCLES + 2);
   localparam int TIMEOUT_CYCLES = 6 * (SORT_CYCLES + 4 * MAX_ENTRIES + 100);

   logic                  clk = 1'b0;
   logic                  reset;
   logic                  sort_start;
   logic                  sort_clear;
   logic                  white_to_move;
   logic                  wr_addr_init;
   logic                  wr;
   move_sort_pkg::entry_t wr_data;
   move_sort_pkg::addr_t  rd_addr;
   move_sort_pkg::entry_t rd_data;
   move_sort_pkg::addr_t  wr_addr;
   logic                  sort_complete;
   integer                seed = 63680;
   move_sort_pkg::entry_t written [MAX_ENTRIES];
   move_sort_pkg::entry_t expected [MAX_ENTRIES];

   always #(CLK_PERIOD / 2) clk = ~clk;

   move_sort move_sort_i
   (
      .clk           (clk),
      .reset         (reset),
      .sort_start    (sort_start),
      .sort_clear    (sort_clear),
      .white_to_move (white_to_move),
      .wr_addr_init  (wr_addr_init),
      .wr            (wr),
      .wr_data       (wr_data),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data),
      .wr_addr       (wr_addr),
      .sort_complete (sort_complete)
   );

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] exp_value);
      assert (actual === exp_value)
      else
         stop_on_error($sformatf("** Error: %s = 0x%h, expected 0x%h", name, actual, exp_value));
   endtask

   // Done is held until cleared and drops right after
   hold_done: assert property (@(posedge clk) disable iff (reset)
      sort_complete && !sort_clear |=> sort_complete)
   else
      stop_on_error("sort_complete dropped before sort_clear");

   drop_done: assert property (@(posedge clk) disable iff (reset)
      sort_complete && sort_clear |=> !sort_complete)
   else
      stop_on_error("sort_complete stayed high after sort_clear");

   task automatic make_entries(input int n);
      logic [31:0] r;
      logic [31:0] pick;
      for (int i = 0; i < n; i++)
      begin
         r          = $random(seed);
         pick       = $random(seed);
         written[i] = r[`MOVE_SORT_RAM_WIDTH-1:0];
         // Narrow evaluations on about half so equal keys show up
         if (pick[31])
            written[i][`MOVE_SORT_EVAL_WIDTH-1:0] = move_sort_pkg::eval_t'($signed(r[3:0]));
         written[i][`MOVE_SORT_CAPTURE_BIT] = (pick[15:0] % 16'd3 == 16'd0);
      end
   endtask

   // True when x belongs strictly ahead of y
   function automatic bit ranks_ahead(input move_sort_pkg::entry_t x,
                                      input move_sort_pkg::entry_t y, input bit white);
      move_sort_pkg::eval_t x_eval;
      move_sort_pkg::eval_t y_eval;
      x_eval = move_sort_pkg::eval_t'(x[`MOVE_SORT_EVAL_WIDTH-1:0]);
      y_eval = move_sort_pkg::eval_t'(y[`MOVE_SORT_EVAL_WIDTH-1:0]);
      if (x[`MOVE_SORT_CAPTURE_BIT] != y[`MOVE_SORT_CAPTURE_BIT])
         return x[`MOVE_SORT_CAPTURE_BIT];
      return white ? (x_eval > y_eval) : (x_eval < y_eval);
   endfunction

   // Expected order from a stable insertion sort
   task automatic build_model(input int n, input bit sorted, input bit white);
      move_sort_pkg::entry_t key;
      int j;
      for (int i = 0; i < n; i++)
         expected[i] = written[i];
      for (int i = 1; i < n && sorted; i++)
      begin
         key = expected[i];
         j   = i - 1;
         while (j >= 0 && ranks_ahead(key, expected[j], white))
         begin
            expected[j + 1] = expected[j];
            j--;
         end
         expected[j + 1] = key;
      end
   endtask

   task automatic load_entries(input int n);
      @(posedge clk);
      wr_addr_init <= 1'b1;
      @(posedge clk);
      wr_addr_init <= 1'b0;
      for (int i = 0; i < n; i++)
      begin
         wr      <= 1'b1;
         wr_data <= written[i];
         @(posedge clk);
      end
      wr <= 1'b0;
      @(posedge clk);
      check_value("wr_addr", 32'(wr_addr), 32'(n));
   endtask

   task automatic compare_ram(input int n);
      for (int i = 0; i < n; i++)
      begin
         @(posedge clk);
         rd_addr <= move_sort_pkg::addr_t'(i);
         @(posedge clk);
         @(negedge clk);
         check_value($sformatf("rd_data[%0d]", i), 32'(rd_data), 32'(expected[i]));
      end
   endtask

   task automatic run_sort(input bit white);
      @(posedge clk);
      white_to_move <= white;
      sort_start    <= 1'b1;
      @(posedge clk);
      sort_start <= 1'b0;
      while (!sort_complete)
         @(posedge clk);
   endtask

   task automatic clear_sort();
      @(posedge clk);
      sort_clear <= 1'b1;
      @(posedge clk);
      sort_clear <= 1'b0;
   endtask

   // Zero or one entry finishes on the cycle after the start edge
   task automatic verify_quick_done(input int n);
      make_entries(n);
      load_entries(n);
      @(posedge clk);
      sort_start <= 1'b1;
      @(posedge clk);
      sort_start <= 1'b0;
      @(negedge clk);
      assert (sort_complete)
      else
         stop_on_error($sformatf("sort with %0d entries did not finish after one cycle", n));
      build_model(n, 1'b0, 1'b0);
      compare_ram(n);
      clear_sort();
   endtask

   initial
   begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Watchdog: the sort never completed within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $fatal(1);
   end

   initial
   begin
      reset         = 1'b1;
      sort_start    = 1'b0;
      sort_clear    = 1'b0;
      white_to_move = 1'b0;
      wr_addr_init  = 1'b0;
      wr            = 1'b0;
      wr_data       = '0;
      rd_addr       = '0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_value("sort_complete", 32'(sort_complete), 32'd0);
      check_value("wr_addr", 32'(wr_addr), 32'd0);

      make_entries(N_ENTRIES);
      load_entries(N_ENTRIES);
      build_model(N_ENTRIES, 1'b0, 1'b0);
      compare_ram(N_ENTRIES);

      run_sort(1'b1);
      build_model(N_ENTRIES, 1'b1, 1'b1);
      compare_ram(N_ENTRIES);
      clear_sort();

      load_entries(N_ENTRIES);
      run_sort(1'b0);
      build_model(N_ENTRIES, 1'b1, 1'b0);
      compare_ram(N_ENTRIES);

      // Start held high across the clear must not restart
      // Watch longer than one pass over already sorted data
      repeat (20) @(posedge clk);
      sort_start <= 1'b1;
      clear_sort();
      repeat ((N_ENTRIES - 1) * PAIR_CYCLES + 10)
      begin
         @(negedge clk);
         assert (!sort_complete)
         else
            stop_on_error("a held sort_start began a new sort");
      end
      compare_ram(N_ENTRIES);
      @(posedge clk);
      sort_start <= 1'b0;
      run_sort(1'b0);
      compare_ram(N_ENTRIES);
      clear_sort();

      verify_quick_done(0);
      verify_quick_done(1);

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// File: move_sort.sv
`timescale 1ns/1ps

module move_sort
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  sort_start,
   input  logic                  sort_clear,
   input  logic                  white_to_move,
   input  logic                  wr_addr_init,
   input  logic                  wr,
   input  move_sort_pkg::entry_t wr_data,
   input  move_sort_pkg::addr_t  rd_addr,
   output move_sort_pkg::entry_t rd_data,
   output move_sort_pkg::addr_t  wr_addr,
   output logic                  sort_complete
);

   logic                  external_io;
   logic                  load_limit;
   logic                  scan_init;
   logic                  scan_step;
   logic                  swap_seen;
   logic                  pass_end;
   logic                  swap_wr;
   logic                  scan_last;
   logic                  pass_more;
   logic                  few_entries;
   logic                  swap_needed;
   move_sort_pkg::addr_t  scan_a_addr;
   move_sort_pkg::addr_t  scan_b_addr;
   move_sort_pkg::entry_t a_rd_data;

   move_sort_ctrl move_sort_ctrl_i
   (
      .clk           (clk),
      .reset         (reset),
      .sort_start    (sort_start),
      .sort_clear    (sort_clear),
      .few_entries   (few_entries),
      .scan_last     (scan_last),
      .pass_more     (pass_more),
      .swap_needed   (swap_needed),
      .external_io   (external_io),
      .load_limit    (load_limit),
      .scan_init     (scan_init),
      .scan_step     (scan_step),
      .swap_seen     (swap_seen),
      .pass_end      (pass_end),
      .swap_wr       (swap_wr),
      .sort_complete (sort_complete)
   );

   sort_scan_counter sort_scan_counter_i
   (
      .clk          (clk),
      .reset        (reset),
      .wr_addr_init (wr_addr_init),
      .wr           (wr),
      .wr_addr      (wr_addr),
      .load_limit   (load_limit),
      .scan_init    (scan_init),
      .scan_step    (scan_step),
      .swap_seen    (swap_seen),
      .pass_end     (pass_end),
      .scan_a_addr  (scan_a_addr),
      .scan_b_addr  (scan_b_addr),
      .scan_last    (scan_last),
      .pass_more    (pass_more),
      .few_entries  (few_entries)
   );

   // Port B output doubles as the external read data
   move_compare move_compare_i
   (
      .a_entry       (a_rd_data),
      .b_entry       (rd_data),
      .white_to_move (white_to_move),
      .swap_needed   (swap_needed)
   );

   move_ram move_ram_i
   (
      .clk         (clk),
      .external_io (external_io),
      .ext_wr      (wr),
      .ext_wr_addr (wr_addr),
      .ext_wr_data (wr_data),
      .ext_rd_addr (rd_addr),
      .scan_a_addr (scan_a_addr),
      .scan_b_addr (scan_b_addr),
      .swap_wr     (swap_wr),
      .a_rd_data   (a_rd_data),
      .b_rd_data   (rd_data)
   );

endmodule

// File: move_sort_ctrl.sv
`timescale 1ns/1ps

module move_sort_ctrl
(
   input  logic clk,
   input  logic reset,
   input  logic sort_start,
   input  logic sort_clear,
   input  logic few_entries,
   input  logic scan_last,
   input  logic pass_more,
   input  logic swap_needed,
   output logic external_io,
   output logic load_limit,
   output logic scan_init,
   output logic scan_step,
   output logic swap_seen,
   output logic pass_end,
   output logic swap_wr,
   output logic sort_complete
);

   move_sort_pkg::sort_state_t state;
   move_sort_pkg::sort_state_t state_next;
   logic                       sort_start_z;
   logic                       start_edge;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         sort_start_z <= 1'b0;
         state        <= move_sort_pkg::IDLE;
      end
      else
      begin
         sort_start_z <= sort_start;
         state        <= state_next;
      end
   end

   // Only a rising edge starts a sort
   assign start_edge = sort_start & ~sort_start_z;

   always_comb
   begin
      state_next = state;
      case (state)
         move_sort_pkg::IDLE:
         begin
            if (start_edge)
            begin
               state_next = few_entries ? move_sort_pkg::DONE : move_sort_pkg::OUTER_INIT;
            end
         end
         move_sort_pkg::OUTER_INIT:
         begin
            state_next = move_sort_pkg::READ_WS_0;
         end
         // Two cycles for RAM read latency
         move_sort_pkg::READ_WS_0:
         begin
            state_next = move_sort_pkg::READ_WS_1;
         end
         move_sort_pkg::READ_WS_1:
         begin
            state_next = move_sort_pkg::COMPARE;
         end
         move_sort_pkg::COMPARE:
         begin
            state_next = swap_needed ? move_sort_pkg::SWAP : move_sort_pkg::INNER;
         end
         move_sort_pkg::SWAP:
         begin
            state_next = move_sort_pkg::INNER;
         end
         move_sort_pkg::INNER:
         begin
            state_next = scan_last ? move_sort_pkg::OUTER_CHECK : move_sort_pkg::READ_WS_0;
         end
         move_sort_pkg::OUTER_CHECK:
         begin
            state_next = pass_more ? move_sort_pkg::OUTER_INIT : move_sort_pkg::DONE;
         end
         move_sort_pkg::DONE:
         begin
            if (sort_clear)
            begin
               state_next = move_sort_pkg::IDLE;
            end
         end
         default:
         begin
            state_next = move_sort_pkg::IDLE;
         end
      endcase
   end

   assign external_io   = (state == move_sort_pkg::IDLE) || (state == move_sort_pkg::DONE);
   assign load_limit    = (state == move_sort_pkg::IDLE);
   assign scan_init     = (state == move_sort_pkg::OUTER_INIT);
   assign scan_step     = (state == move_sort_pkg::INNER);
   assign swap_seen     = (state == move_sort_pkg::SWAP);
   assign swap_wr       = (state == move_sort_pkg::SWAP);
   assign pass_end      = (state == move_sort_pkg::OUTER_CHECK);
   assign sort_complete = (state == move_sort_pkg::DONE);

endmodule

// File: sort_scan_counter.sv
`timescale 1ns/1ps

module sort_scan_counter
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 wr_addr_init,
   input  logic                 wr,
   output move_sort_pkg::addr_t wr_addr,
   input  logic                 load_limit,
   input  logic                 scan_init,
   input  logic                 scan_step,
   input  logic                 swap_seen,
   input  logic                 pass_end,
   output move_sort_pkg::addr_t scan_a_addr,
   output move_sort_pkg::addr_t scan_b_addr,
   output logic                 scan_last,
   output logic                 pass_more,
   output logic                 few_entries
);

   move_sort_pkg::addr_t limit;
   move_sort_pkg::addr_t limit_m1;
   move_sort_pkg::addr_t last_swap;

   // Write counter doubles as entry count
   always_ff @(posedge clk)
   begin
      if (reset || wr_addr_init)
      begin
         wr_addr <= '0;
      end
      else if (wr)
      begin
         wr_addr <= wr_addr + move_sort_pkg::addr_t'(1);
      end
   end

   // Pass limit shrinks to the last swap position
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         limit <= '0;
      end
      else if (load_limit)
      begin
         limit <= wr_addr;
      end
      else if (pass_end)
      begin
         limit <= last_swap;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset || scan_init)
      begin
         scan_a_addr <= '0;
         scan_b_addr <= move_sort_pkg::addr_t'(1);
         last_swap   <= '0;
      end
      else
      begin
         if (scan_step)
         begin
            scan_a_addr <= scan_a_addr + move_sort_pkg::addr_t'(1);
            scan_b_addr <= scan_b_addr + move_sort_pkg::addr_t'(1);
         end
         if (swap_seen)
         begin
            last_swap <= scan_b_addr;
         end
      end
   end

   assign limit_m1    = limit - move_sort_pkg::addr_t'(1);
   assign scan_last   = (scan_b_addr == limit_m1);
   assign pass_more   = (last_swap > move_sort_pkg::addr_t'(1));
   assign few_entries = (wr_addr <= move_sort_pkg::addr_t'(1));

endmodule

// File: move_compare.sv
`timescale 1ns/1ps

`include "move_sort_config.svh"

module move_compare
(
   input  move_sort_pkg::entry_t a_entry,
   input  move_sort_pkg::entry_t b_entry,
   input  logic                  white_to_move,
   output logic                  swap_needed
);

   logic                 a_capture;
   logic                 b_capture;
   move_sort_pkg::eval_t a_eval;
   move_sort_pkg::eval_t b_eval;
   logic                 eval_out_of_order;

   assign a_capture = a_entry[`MOVE_SORT_CAPTURE_BIT];
   assign b_capture = b_entry[`MOVE_SORT_CAPTURE_BIT];
   assign a_eval    = move_sort_pkg::eval_t'(a_entry[`MOVE_SORT_EVAL_WIDTH-1:0]);
   assign b_eval    = move_sort_pkg::eval_t'(b_entry[`MOVE_SORT_EVAL_WIDTH-1:0]);

   // Strict compare keeps equal keys in place
   assign eval_out_of_order = white_to_move ? (a_eval < b_eval) : (a_eval > b_eval);

   // Captures always ahead of quiet moves
   assign swap_needed = (b_capture & ~a_capture) |
                        ((a_capture == b_capture) & eval_out_of_order);

endmodule

// File: move_ram.sv
`timescale 1ns/1ps

`include "move_sort_config.svh"

module move_ram
(
   input  logic                 clk,
   input  logic                 external_io,
   input  logic                 ext_wr,
   input  move_sort_pkg::addr_t ext_wr_addr,
   input  move_sort_pkg::entry_t ext_wr_data,
   input  move_sort_pkg::addr_t ext_rd_addr,
   input  move_sort_pkg::addr_t scan_a_addr,
   input  move_sort_pkg::addr_t scan_b_addr,
   input  logic                 swap_wr,
   output move_sort_pkg::entry_t a_rd_data,
   output move_sort_pkg::entry_t b_rd_data
);

   move_sort_pkg::entry_t mem [`MOVE_SORT_MAX_POSITIONS];

   move_sort_pkg::addr_t  port_a_addr;
   move_sort_pkg::addr_t  port_b_addr;
   move_sort_pkg::entry_t port_a_wr_data;
   logic                  port_a_wr_en;

   // External writes go through port A, external reads through port B
   assign port_a_addr    = external_io ? ext_wr_addr : scan_a_addr;
   assign port_b_addr    = external_io ? ext_rd_addr : scan_b_addr;
   assign port_a_wr_en   = external_io ? ext_wr : swap_wr;

   // Swap crosses the registered read outputs
   assign port_a_wr_data = external_io ? ext_wr_data : b_rd_data;

   always_ff @(posedge clk)
   begin
      if (port_a_wr_en)
      begin
         mem[port_a_addr] <= port_a_wr_data;
      end
      if (swap_wr)
      begin
         mem[port_b_addr] <= a_rd_data;
      end
      a_rd_data <= mem[port_a_addr];
      b_rd_data <= mem[port_b_addr];
   end

endmodule

// File: move_sort_pkg.sv
`include "move_sort_config.svh"

package move_sort_pkg;

   localparam int ADDR_WIDTH = $clog2(`MOVE_SORT_MAX_POSITIONS);

   typedef logic [ADDR_WIDTH-1:0] addr_t;

   typedef logic [`MOVE_SORT_RAM_WIDTH-1:0] entry_t;

   typedef logic signed [`MOVE_SORT_EVAL_WIDTH-1:0] eval_t;

   // Sort controller states
   typedef enum logic [3:0]
   {
      IDLE,
      OUTER_INIT,
      READ_WS_0,
      READ_WS_1,
      COMPARE,
      SWAP,
      INNER,
      OUTER_CHECK,
      DONE
   } sort_state_t;

endpackage

// File: move_sort_config.svh
`ifndef MOVE_SORT_CONFIG_SVH
`define MOVE_SORT_CONFIG_SVH

// Capacity of the move RAM in entries
`define MOVE_SORT_MAX_POSITIONS 64

// Bits per move entry
`define MOVE_SORT_RAM_WIDTH 24

// Signed evaluation in the low bits of an entry
`define MOVE_SORT_EVAL_WIDTH 16

// Capture flag, two bits above the evaluation field
`define MOVE_SORT_CAPTURE_BIT 18

`endif
